// File: sources.f
rtl/mpuDispatchPkg.sv
rtl/ringPointers.sv
rtl/hazardTable.sv
rtl/wbCommandDecode.sv
rtl/dispatchStatus.sv
rtl/mpuDispatch.sv
sim/mpuDispatch_assertions.sv
sim/mpuDispatchTb.sv

// File: Bender.yml
package:
  name: mpu_dispatch

sources:
  - files:
      - rtl/mpuDispatchPkg.sv
      - rtl/ringPointers.sv
      - rtl/hazardTable.sv
      - rtl/wbCommandDecode.sv
      - rtl/dispatchStatus.sv
      - rtl/mpuDispatch.sv
  - target: simulation
    files:
      - sim/mpuDispatch_assertions.sv
      - sim/mpuDispatchTb.sv

// File: sim/mpuDispatchTb.sv
//////////////////////////////////////////////////
// Directed and LFSR-driven tests of the dispatch
// front end against a queue reference model
//////////////////////////////////////////////////
`default_nettype none

module mpuDispatchTb;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 3;
	localparam int AckLimit = 40;
	localparam int IssueLimit = 100;
	localparam int StallCycles = 20;
	localparam int BlockCycles = 12;
	localparam int RetireSettle = mpuDispatchPkg::NumEntries + 2;
	localparam int RandomOps = 60;
	localparam int RandomTries = 400;
	localparam int DrainTries = 60;
	localparam logic [31:0] LfsrSeed = 32'hfe64_190d;
	// Small ID range so sources collide often
	localparam logic [7:0] ThreadBase = 8'h40;

	//////////////////////////////////////////////////
	// Watchdog budget, summed over the tests
	//////////////////////////////////////////////////
	localparam int OpCycles = AckLimit + 4;
	localparam int BudgetReset = 3 * OpCycles + 2 * ResetCycles;
	localparam int BudgetInOrder = 4 * OpCycles + IssueLimit;
	localparam int BudgetBlocked = 5 * OpCycles + BlockCycles + IssueLimit;
	localparam int BudgetFull = (mpuDispatchPkg::NumEntries + 4) * OpCycles + StallCycles
		+ 2 * IssueLimit + 2 * ResetCycles;
	localparam int BudgetOutOfOrder = 7 * OpCycles + 3 * RetireSettle;
	localparam int BudgetRandom = (RandomTries + DrainTries + 2) * OpCycles + RetireSettle
		+ 2 * ResetCycles;
	localparam int WatchdogCycles = BudgetReset + BudgetInOrder + BudgetBlocked + BudgetFull
		+ BudgetOutOfOrder + BudgetRandom;

	logic clock;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	mpuDispatchPkg::regAddrT adr;
	logic [mpuDispatchPkg::WbDataWidth-1:0] datW;
	logic [mpuDispatchPkg::WbDataWidth-1:0] datR;
	logic ack;
	logic commitValid;
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] commitNo;
	logic issueValid;
	mpuDispatchPkg::issueT issue;

	// Reference model: commands waiting, issued set, slot ring
	mpuDispatchPkg::commandT pendingCmd[$];
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] pendingSlot[$];
	logic [mpuDispatchPkg::ThreadIdWidth-1:0] outThread[$];
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] outSlot[$];
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] ringSlot[$];
	bit ringFreed[$];
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] nextSlot;
	int issueCount;

	int errorCount;
	int checkCount;
	int testCount;
	int testErrorBase;
	logic [31:0] lfsrState;

	mpuDispatch uut (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.datR(datR),
		.ack(ack),
		.commitValid(commitValid),
		.commitNo(commitNo),
		.issueValid(issueValid),
		.issue(issue)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(ClockPeriod / 2) clock = ~clock;
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", WatchdogCycles);
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic reportFailure(input string message);
		errorCount++;
		$display("Error: %s", message);
	endtask

	task automatic startTest();
		testErrorBase = errorCount;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %0d %s: %s", testCount, name,
			(errorCount == testErrorBase) ? "ok" : "failed");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [7:0] takeBits(input int count);
		logic [7:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[6:0], lfsrState[0]};
		end
		return bits;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	task automatic clearModel();
		pendingCmd.delete();
		pendingSlot.delete();
		outThread.delete();
		outSlot.delete();
		ringSlot.delete();
		ringFreed.delete();
		nextSlot = '0;
		issueCount = 0;
	endtask

	// Slots fill in ring order
	task automatic enqueueCommand(input mpuDispatchPkg::commandT cmd);
		pendingCmd.push_back(cmd);
		pendingSlot.push_back(nextSlot);
		ringSlot.push_back(nextSlot);
		ringFreed.push_back(1'b0);
		nextSlot = mpuDispatchPkg::EntryIndexWidth'((int'(nextSlot) + 1)
			% mpuDispatchPkg::NumEntries);
	endtask

	task automatic retireCommit(input logic [mpuDispatchPkg::EntryIndexWidth-1:0] slot);
		int outIndex;
		int ringIndex;
		outIndex = -1;
		ringIndex = -1;
		foreach (outSlot[i]) begin
			if (outIndex < 0 && outSlot[i] == slot) begin
				outIndex = i;
			end
		end
		if (outIndex >= 0) begin
			outSlot.delete(outIndex);
			outThread.delete(outIndex);
		end
		// Oldest live copy of that slot
		foreach (ringSlot[i]) begin
			if (ringIndex < 0 && ringSlot[i] == slot && !ringFreed[i]) begin
				ringIndex = i;
			end
		end
		if (ringIndex >= 0) begin
			ringFreed[ringIndex] = 1'b1;
		end
		// Retire walks freed slots in order
		while (ringFreed.size() > 0 && ringFreed[0]) begin
			void'(ringFreed.pop_front());
			void'(ringSlot.pop_front());
		end
	endtask

	function automatic logic threadOutstanding(
		input logic [mpuDispatchPkg::ThreadIdWidth-1:0] id);
		foreach (outThread[i]) begin
			if (outThread[i] == id) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Each pulse must be the oldest waiting command
	task automatic recordIssue();
		mpuDispatchPkg::commandT cmd;
		logic [mpuDispatchPkg::EntryIndexWidth-1:0] slot;
		if (pendingCmd.size() == 0) begin
			reportFailure("issue pulse with no command waiting");
		end else begin
			cmd = pendingCmd.pop_front();
			slot = pendingSlot.pop_front();
			if (cmd.op == mpuDispatchPkg::opDispatchAfter && threadOutstanding(cmd.sourceId)) begin
				reportFailure("command issued while its source thread was outstanding");
			end
			checkValue("issue.threadId", issue.threadId, cmd.threadId);
			checkValue("issue.issueNo", issue.issueNo, slot);
			outThread.push_back(cmd.threadId);
			outSlot.push_back(slot);
			issueCount++;
		end
	endtask

	// Issue monitor, sampled mid-cycle
	always @(negedge clock) begin
		if (!reset && issueValid) begin
			recordIssue();
		end
	end

	//////////////////////////////////////////////////
	// Bus and commit drivers
	//////////////////////////////////////////////////
	task automatic applyReset();
		@(posedge clock);
		reset <= 1'b1;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		commitValid <= 1'b0;
		repeat (ResetCycles) @(posedge clock);
		reset <= 1'b0;
		clearModel();
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(posedge clock);
	endtask

	task automatic startWrite(input mpuDispatchPkg::commandT cmd);
		@(posedge clock);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= mpuDispatchPkg::regCommand;
		datW <= mpuDispatchPkg::WbDataWidth'(cmd);
		enqueueCommand(cmd);
	endtask

	task automatic waitAck(input int limit, output logic acked);
		int waited;
		acked = 1'b0;
		waited = 0;
		while (!acked && waited < limit) begin
			@(negedge clock);
			acked = ack;
			waited++;
		end
	endtask

	// Ack cycle ends here
	task automatic releaseBus();
		@(posedge clock);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wbWrite(input mpuDispatchPkg::commandT cmd);
		logic acked;
		startWrite(cmd);
		waitAck(AckLimit, acked);
		if (!acked) begin
			reportFailure("command write got no ack");
		end
		releaseBus();
	endtask

	task automatic wbRead(input mpuDispatchPkg::regAddrT address,
		output logic [mpuDispatchPkg::WbDataWidth-1:0] data);
		logic acked;
		@(posedge clock);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= address;
		waitAck(AckLimit, acked);
		data = datR;
		if (!acked) begin
			reportFailure("register read got no ack");
		end
		releaseBus();
	endtask

	task automatic commitEntry(input logic [mpuDispatchPkg::EntryIndexWidth-1:0] slot);
		@(posedge clock);
		commitValid <= 1'b1;
		commitNo <= slot;
		retireCommit(slot);
		@(posedge clock);
		commitValid <= 1'b0;
	endtask

	task automatic waitForIssues(input int target);
		int waited;
		waited = 0;
		while (issueCount < target && waited < IssueLimit) begin
			@(posedge clock);
			waited++;
		end
		if (issueCount < target) begin
			reportFailure("expected issue did not arrive");
		end
	endtask

	// Status fields against the model
	task automatic compareStatus();
		logic [mpuDispatchPkg::WbDataWidth-1:0] data;
		mpuDispatchPkg::statusT status;
		wbRead(mpuDispatchPkg::regStatus, data);
		status = data[$bits(mpuDispatchPkg::statusT)-1:0];
		checkValue("datR upper bits", data >> $bits(mpuDispatchPkg::statusT), 0);
		checkValue("status.occupancy", status.occupancy, ringSlot.size());
		checkValue("status.outstanding", status.outstanding, outSlot.size());
		checkValue("status.issueTotal", status.issueTotal, issueCount % 256);
	endtask

	function automatic mpuDispatchPkg::commandT makeCommand(
		input mpuDispatchPkg::commandOpT op,
		input logic [7:0] sourceId,
		input logic [7:0] threadId
	);
		mpuDispatchPkg::commandT cmd;
		cmd.op = op;
		cmd.sourceId = sourceId;
		cmd.threadId = threadId;
		return cmd;
	endfunction

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic resetStateTest();
		logic [mpuDispatchPkg::WbDataWidth-1:0] data;
		startTest();
		compareStatus();
		// Command register reads as zero
		wbRead(mpuDispatchPkg::regCommand, data);
		checkValue("datR command read", data, 0);
		checkValue("issues after reset", issueCount, 0);
		finishTest("reset state");
	endtask

	task automatic inOrderIssueTest();
		startTest();
		wbWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h11));
		wbWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h22));
		wbWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h33));
		waitForIssues(3);
		settle(2);
		compareStatus();
		finishTest("in-order issue");
	endtask

	// Waits on 0x22 in slot 1, younger command stuck behind
	task automatic blockedSourceTest();
		startTest();
		wbWrite(makeCommand(mpuDispatchPkg::opDispatchAfter, 8'h22, 8'h44));
		wbWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h55));
		settle(BlockCycles);
		checkValue("issues while source busy", issueCount, 3);
		commitEntry(1);
		waitForIssues(5);
		settle(2);
		compareStatus();
		finishTest("blocked source");
	endtask

	task automatic fullTableTest();
		logic acked;
		int i;
		startTest();
		applyReset();
		for (i = 0; i < mpuDispatchPkg::NumEntries; i++) begin
			wbWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h80 + 8'(i)));
		end
		waitForIssues(mpuDispatchPkg::NumEntries);
		// Ninth write stalls until slot 0 frees
		startWrite(makeCommand(mpuDispatchPkg::opDispatch, 8'h00, 8'h90));
		waitAck(StallCycles, acked);
		if (acked) begin
			reportFailure("write to a full table was acknowledged");
		end
		commitEntry(0);
		waitAck(AckLimit, acked);
		if (!acked) begin
			reportFailure("write stayed blocked after a commit");
		end
		releaseBus();
		waitForIssues(mpuDispatchPkg::NumEntries + 1);
		settle(2);
		compareStatus();
		finishTest("full table");
	endtask

	// Retire pointer still parked on slot 1
	task automatic outOfOrderCommitTest();
		startTest();
		commitEntry(3);
		commitEntry(5);
		settle(2);
		compareStatus();
		commitEntry(1);
		settle(RetireSettle);
		compareStatus();
		// Frees 2, retire runs through 3
		commitEntry(2);
		settle(RetireSettle);
		compareStatus();
		finishTest("out-of-order commit");
	endtask

	task automatic randomTrafficTest();
		mpuDispatchPkg::commandT cmd;
		logic doCommit;
		int ops;
		int tries;
		int pick;
		int written;
		startTest();
		applyReset();
		ops = 0;
		tries = 0;
		written = 0;
		while (ops < RandomOps && tries < RandomTries) begin
			tries++;
			doCommit = takeBits(1) != 0;
			if (doCommit && outSlot.size() > 0) begin
				pick = int'(takeBits(3)) % outSlot.size();
				commitEntry(outSlot[pick]);
				ops++;
			end else if (ringSlot.size() < mpuDispatchPkg::NumEntries) begin
				cmd.op = (takeBits(1) != 0) ? mpuDispatchPkg::opDispatchAfter
					: mpuDispatchPkg::opDispatch;
				cmd.sourceId = ThreadBase + takeBits(3);
				cmd.threadId = ThreadBase + takeBits(3);
				wbWrite(cmd);
				written++;
				ops++;
			end else begin
				settle(1);
			end
		end
		// Drain everything still in the table
		tries = 0;
		while ((pendingCmd.size() > 0 || outSlot.size() > 0) && tries < DrainTries) begin
			tries++;
			if (outSlot.size() > 0) begin
				commitEntry(outSlot[0]);
			end else begin
				settle(1);
			end
		end
		if (pendingCmd.size() > 0 || outSlot.size() > 0) begin
			reportFailure("table did not drain after random traffic");
		end
		checkValue("random operations", ops, RandomOps);
		checkValue("issued commands", issueCount, written);
		settle(RetireSettle);
		compareStatus();
		finishTest("random traffic");
	endtask

	initial begin
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = mpuDispatchPkg::regCommand;
		datW = '0;
		commitValid = 1'b0;
		commitNo = '0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		testErrorBase = 0;
		lfsrState = LfsrSeed;
		clearModel();
		applyReset();
		resetStateTest();
		inOrderIssueTest();
		blockedSourceTest();
		fullTableTest();
		outOfOrderCommitTest();
		randomTrafficTest();
		if (uut.decode.busChecks.failures + uut.table0.tableChecks.failures > 0) begin
			reportFailure("protocol assertions fired during the run");
		end
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/mpuDispatch_assertions.sv
//////////////////////////////////////////////////
// Protocol checks bound into the Wishbone slave
// and the hazard table
//////////////////////////////////////////////////
`default_nettype none

module mpuDispatchAssertions (
	input wire logic clock,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire logic issueValid,
	input wire logic issueStep,
	input wire logic [mpuDispatchPkg::CountWidth-1:0] pendingIssue,
	input wire logic headWaiting,
	input wire logic commitValid,
	input wire logic commitHit
);

	// Failed checks so far
	int failures = 0;

	// Ack only inside an active bus cycle
	ackInCycle: assert property (@(posedge clock) disable iff (reset) ack |-> cyc && stb)
		else begin
			$error("ack outside an active bus cycle");
			failures++;
		end

	// Issue register held clear through reset
	quietInReset: assert property (@(posedge clock) $past(reset) |-> !issueValid)
		else begin
			$error("issueValid high during reset");
			failures++;
		end

	// Commit must name a valid and issued slot
	commitTarget: assert property (@(posedge clock) disable iff (reset)
		commitValid |-> commitHit)
		else begin
			$error("commit of a slot that is not issued");
			failures++;
		end

	// Issue only from a written slot not yet issued
	issueNeedsEntry: assert property (@(posedge clock) disable iff (reset)
		issueStep |-> headWaiting)
		else begin
			$error("issue from a slot that holds no waiting command");
			failures++;
		end

	// Zero pending count leaves nothing waiting at the head
	pendingMatchesHead: assert property (@(posedge clock) disable iff (reset)
		pendingIssue == '0 |-> !headWaiting)
		else begin
			$error("command waiting at the head while no issue is pending");
			failures++;
		end

endmodule

// Bus side with the table ports tied off
bind wbCommandDecode mpuDispatchAssertions busChecks (
	.clock(clock),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.issueValid(1'b0),
	.issueStep(1'b0),
	.pendingIssue('0),
	.headWaiting(1'b0),
	.commitValid(1'b0),
	.commitHit(1'b1)
);

// Table side with the bus ports tied off
bind hazardTable mpuDispatchAssertions tableChecks (
	.clock(clock),
	.reset(reset),
	.cyc(1'b0),
	.stb(1'b0),
	.ack(1'b0),
	.issueValid(issueValid),
	.issueStep(canIssue),
	.pendingIssue(pendingIssue),
	.headWaiting(entries[issueIndex].valid && !entries[issueIndex].issued),
	.commitValid(commitValid),
	.commitHit(entries[commitNo].valid && entries[commitNo].issued)
);

`default_nettype wire

// File: rtl/mpuDispatch.sv
//////////////////////////////////////////////////
// Dispatch front end top: Wishbone command decode,
// hazard table and status readback
//////////////////////////////////////////////////
`default_nettype none

module mpuDispatch (
	input wire logic clock,
	input wire logic reset,
	// Wishbone slave
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire mpuDispatchPkg::regAddrT adr,
	input wire logic [mpuDispatchPkg::WbDataWidth-1:0] datW,
	output logic [mpuDispatchPkg::WbDataWidth-1:0] datR,
	output logic ack,
	// Commit from the consumer
	input wire logic commitValid,
	input wire logic [mpuDispatchPkg::EntryIndexWidth-1:0] commitNo,
	// Issue to the consumer
	output logic issueValid,
	output mpuDispatchPkg::issueT issue
);

	mpuDispatchPkg::commandT command;
	mpuDispatchPkg::statusT status;
	logic commandValid;
	logic tableFull;
	logic [mpuDispatchPkg::CountWidth-1:0] occupancy;
	logic [mpuDispatchPkg::CountWidth-1:0] outstanding;

	wbCommandDecode decode (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.datR(datR),
		.ack(ack),
		.command(command),
		.commandValid(commandValid),
		.tableFull(tableFull),
		.status(status)
	);

	hazardTable table0 (
		.clock(clock),
		.reset(reset),
		.commandValid(commandValid),
		.command(command),
		.tableFull(tableFull),
		.commitValid(commitValid),
		.commitNo(commitNo),
		.issueValid(issueValid),
		.issue(issue),
		.occupancy(occupancy),
		.outstanding(outstanding)
	);

	dispatchStatus statusRegs (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.occupancy(occupancy),
		.outstanding(outstanding),
		.status(status)
	);

endmodule

`default_nettype wire

// File: rtl/dispatchStatus.sv
//////////////////////////////////////////////////
// Issue counter and registered status word for
// Wishbone reads of the status register
//////////////////////////////////////////////////
`default_nettype none

module dispatchStatus (
	input wire logic clock,
	input wire logic reset,
	input wire logic issueValid,
	input wire logic [mpuDispatchPkg::CountWidth-1:0] occupancy,
	input wire logic [mpuDispatchPkg::CountWidth-1:0] outstanding,
	output mpuDispatchPkg::statusT status
);

	logic [7:0] issueCount;
	logic [7:0] issueCountNext;

	// Wraps at 256
	assign issueCountNext = issueCount + 8'(issueValid);

	always_ff @(posedge clock) begin
		if (reset) begin
			issueCount <= '0;
		end else begin
			issueCount <= issueCountNext;
		end
	end

	// Status word, one cycle behind the table
	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else begin
			status.issueTotal <= issueCountNext;
			status.occupancy <= occupancy;
			status.outstanding <= outstanding;
		end
	end

endmodule

`default_nettype wire

// File: rtl/wbCommandDecode.sv
//////////////////////////////////////////////////
// Wishbone classic slave for dispatch commands;
// withholds ack while the hazard table is full
//////////////////////////////////////////////////
`default_nettype none

module wbCommandDecode (
	input wire logic clock,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire mpuDispatchPkg::regAddrT adr,
	input wire logic [mpuDispatchPkg::WbDataWidth-1:0] datW,
	output logic [mpuDispatchPkg::WbDataWidth-1:0] datR,
	output logic ack,
	output mpuDispatchPkg::commandT command,
	output logic commandValid,
	input wire logic tableFull,
	input wire mpuDispatchPkg::statusT status
);

	mpuDispatchPkg::decodeStateT state;
	logic reqWrite;
	mpuDispatchPkg::regAddrT reqAdr;
	logic commandWrite;
	logic requestDone;

	// Registered request waiting in stAck
	assign commandWrite = (state == mpuDispatchPkg::stAck) && reqWrite
		&& (reqAdr == mpuDispatchPkg::regCommand);

	// One pulse per write, held off while full
	assign commandValid = commandWrite && !tableFull;

	// Anything except a blocked command write ends here
	assign requestDone = (state == mpuDispatchPkg::stAck) && !(commandWrite && tableFull);

	//////////////////////////////////////////////////
	// Slave FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mpuDispatchPkg::stIdle;
			ack <= 1'b0;
		end else begin
			// Ack lands one cycle after the request completes
			ack <= requestDone;
			case (state)
				mpuDispatchPkg::stIdle: begin
					// Skip the ack cycle, host still holds stb there
					if (cyc && stb && !ack) begin
						state <= mpuDispatchPkg::stAck;
					end
				end
				mpuDispatchPkg::stAck: begin
					if (requestDone) begin
						state <= mpuDispatchPkg::stIdle;
					end
				end
				default: begin
					state <= mpuDispatchPkg::stIdle;
				end
			endcase
		end
	end

	// Request capture
	always_ff @(posedge clock) begin
		if (state == mpuDispatchPkg::stIdle && cyc && stb && !ack) begin
			reqWrite <= we;
			reqAdr <= adr;
			// Command sits in the low 17 bits
			command <= datW[$bits(mpuDispatchPkg::commandT)-1:0];
		end
	end

	// Read mux, command register reads as zero
	always_comb begin
		datR = '0;
		if (reqAdr == mpuDispatchPkg::regStatus) begin
			datR = {{(mpuDispatchPkg::WbDataWidth - $bits(mpuDispatchPkg::statusT)){1'b0}},
				status};
		end
	end

endmodule

`default_nettype wire

// File: rtl/hazardTable.sv
//////////////////////////////////////////////////
// In-order hazard table: holds commands, checks the
// source thread, issues and frees slots on commit
//////////////////////////////////////////////////
`default_nettype none

module hazardTable (
	input wire logic clock,
	input wire logic reset,
	input wire logic commandValid,
	input wire mpuDispatchPkg::commandT command,
	output logic tableFull,
	input wire logic commitValid,
	input wire logic [mpuDispatchPkg::EntryIndexWidth-1:0] commitNo,
	output logic issueValid,
	output mpuDispatchPkg::issueT issue,
	output logic [mpuDispatchPkg::CountWidth-1:0] occupancy,
	output logic [mpuDispatchPkg::CountWidth-1:0] outstanding
);

	mpuDispatchPkg::entryT entries [mpuDispatchPkg::NumEntries];
	mpuDispatchPkg::entryT head;

	logic [mpuDispatchPkg::EntryIndexWidth-1:0] writeIndex;
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] issueIndex;
	logic [mpuDispatchPkg::EntryIndexWidth-1:0] retireIndex;
	logic [mpuDispatchPkg::CountWidth-1:0] pendingIssue;

	logic writeEntry;
	logic sourceBusy;
	logic canIssue;
	logic retireEntry;

	assign tableFull = occupancy == mpuDispatchPkg::CountWidth'(mpuDispatchPkg::NumEntries);
	assign writeEntry = commandValid && !tableFull;

	// Oldest entry not yet issued
	assign head = entries[issueIndex];

	//////////////////////////////////////////////////
	// Dependency check
	//////////////////////////////////////////////////
	// Source busy while any issued entry still holds it
	always_comb begin
		sourceBusy = 1'b0;
		for (int i = 0; i < mpuDispatchPkg::NumEntries; i++) begin
			if (entries[i].valid && entries[i].issued
					&& entries[i].threadId == head.sourceId) begin
				sourceBusy = 1'b1;
			end
		end
	end

	assign canIssue = (pendingIssue != '0) && (!head.hasSource || !sourceBusy);

	// Oldest slot already committed, step past it
	assign retireEntry = (occupancy != '0) && !entries[retireIndex].valid;

	// Valid and issued entries
	always_comb begin
		outstanding = '0;
		for (int i = 0; i < mpuDispatchPkg::NumEntries; i++) begin
			if (entries[i].valid && entries[i].issued) begin
				outstanding = outstanding + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Entry storage
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mpuDispatchPkg::NumEntries; i++) begin
				entries[i].valid <= 1'b0;
				entries[i].issued <= 1'b0;
			end
		end else begin
			// New command into the free slot
			if (writeEntry) begin
				entries[writeIndex].valid <= 1'b1;
				entries[writeIndex].issued <= 1'b0;
				entries[writeIndex].hasSource <= command.op == mpuDispatchPkg::opDispatchAfter;
				entries[writeIndex].sourceId <= command.sourceId;
				entries[writeIndex].threadId <= command.threadId;
			end
			if (canIssue) begin
				entries[issueIndex].issued <= 1'b1;
			end
			// Commit frees the slot at this edge
			if (commitValid) begin
				entries[commitNo].valid <= 1'b0;
				entries[commitNo].issued <= 1'b0;
			end
		end
	end

	// Issue pulse, one cycle after the decision
	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid <= 1'b0;
		end else begin
			issueValid <= canIssue;
		end
	end

	// Issue payload, slot index doubles as issue number
	always_ff @(posedge clock) begin
		if (canIssue) begin
			issue.threadId <= head.threadId;
			issue.issueNo <= issueIndex;
		end
	end

	ringPointers pointers (
		.clock(clock),
		.reset(reset),
		.write(writeEntry),
		.issue(canIssue),
		.retire(retireEntry),
		.writeIndex(writeIndex),
		.issueIndex(issueIndex),
		.retireIndex(retireIndex),
		.occupancy(occupancy),
		.pendingIssue(pendingIssue)
	);

endmodule

`default_nettype wire

// File: rtl/ringPointers.sv
//////////////////////////////////////////////////
// Write, issue and retire pointers of the hazard
// table ring, with occupancy and pending counts
//////////////////////////////////////////////////
`default_nettype none

module ringPointers (
	input wire logic clock,
	input wire logic reset,
	input wire logic write,
	input wire logic issue,
	input wire logic retire,
	output logic [mpuDispatchPkg::EntryIndexWidth-1:0] writeIndex,
	output logic [mpuDispatchPkg::EntryIndexWidth-1:0] issueIndex,
	output logic [mpuDispatchPkg::EntryIndexWidth-1:0] retireIndex,
	output logic [mpuDispatchPkg::CountWidth-1:0] occupancy,
	output logic [mpuDispatchPkg::CountWidth-1:0] pendingIssue
);

	// Step one slot, wrap at the table end
	function automatic logic [mpuDispatchPkg::EntryIndexWidth-1:0] nextIndex(
		input logic [mpuDispatchPkg::EntryIndexWidth-1:0] index
	);
		if (index == mpuDispatchPkg::EntryIndexWidth'(mpuDispatchPkg::NumEntries - 1)) begin
			return '0;
		end
		return index + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			writeIndex <= '0;
			issueIndex <= '0;
			retireIndex <= '0;
			occupancy <= '0;
			pendingIssue <= '0;
		end else begin
			if (write) begin
				writeIndex <= nextIndex(writeIndex);
			end
			if (issue) begin
				issueIndex <= nextIndex(issueIndex);
			end
			if (retire) begin
				retireIndex <= nextIndex(retireIndex);
			end
			// Write minus retire
			occupancy <= occupancy + mpuDispatchPkg::CountWidth'(write)
				- mpuDispatchPkg::CountWidth'(retire);
			// Write minus issue
			pendingIssue <= pendingIssue + mpuDispatchPkg::CountWidth'(write)
				- mpuDispatchPkg::CountWidth'(issue);
		end
	end

endmodule

`default_nettype wire

// File: rtl/mpuDispatchPkg.sv
//////////////////////////////////////////////////
// Sizes, encodings and structs shared by the MPU
// dispatch front end and its testbench
//////////////////////////////////////////////////
`default_nettype none

package mpuDispatchPkg;

	// Hazard table geometry
	localparam int NumEntries = 8;
	localparam int EntryIndexWidth = 3;
	// One extra bit so a full table counts to 8
	localparam int CountWidth = 4;
	localparam int ThreadIdWidth = 8;
	localparam int WbDataWidth = 32;

	// Command bit 16
	typedef enum logic [0:0] {
		opDispatch = 1'b0,
		opDispatchAfter = 1'b1
	} commandOpT;

	// Word addresses on the slave port
	typedef enum logic [0:0] {
		regCommand = 1'b0,
		regStatus = 1'b1
	} regAddrT;

	typedef enum logic [0:0] {
		stIdle = 1'b0,
		stAck = 1'b1
	} decodeStateT;

	// Host command word, bits 16:0
	typedef struct packed {
		commandOpT op;
		logic [ThreadIdWidth-1:0] sourceId;
		logic [ThreadIdWidth-1:0] threadId;
	} commandT;

	// One hazard table slot
	typedef struct packed {
		logic valid;
		logic issued;
		logic hasSource;
		logic [ThreadIdWidth-1:0] sourceId;
		logic [ThreadIdWidth-1:0] threadId;
	} entryT;

	// Issue to the thread engine
	typedef struct packed {
		logic [ThreadIdWidth-1:0] threadId;
		logic [EntryIndexWidth-1:0] issueNo;
	} issueT;

	// Status word, zero-extended on read
	typedef struct packed {
		logic [7:0] issueTotal;
		logic [CountWidth-1:0] occupancy;
		logic [CountWidth-1:0] outstanding;
	} statusT;

endpackage

`default_nettype wire
